/* logic/correlator_pkg.sv */
package correlator_pkg;

  // Handshake phase of the visibility sender
  typedef enum logic [1:0] {
    SEND_IDLE,
    SEND_REQ,
    SEND_RELEASE
  } sender_state_t;

  // Accumulator width in bits
  // 2**WIDTH must exceed twice the frame length
  parameter int DEFAULT_WIDTH = 8;

  // Samples per integration frame
  parameter int DEFAULT_LENGTH = 16;

  // Visibility FIFO entries
  parameter int DEFAULT_DEPTH = 4;

endpackage

/* logic/vis_push_if.sv */
`timescale 1ns/1ps

// One visibility per valid cycle, no stall
interface vis_push_if #(
  parameter int WIDTH = correlator_pkg::DEFAULT_WIDTH
);

  logic             valid;
  logic [WIDTH-1:0] re;
  logic [WIDTH-1:0] im;

  modport source (
    output valid,
    output re,
    output im
  );

  modport sink (
    input valid,
    input re,
    input im
  );

endinterface

/* logic/vis_pop_if.sv */
`timescale 1ns/1ps

// Head entry of the FIFO, removed by a one-cycle take
interface vis_pop_if #(
  parameter int WIDTH = correlator_pkg::DEFAULT_WIDTH
);

  logic             avail;
  logic             take;
  logic [WIDTH-1:0] re;
  logic [WIDTH-1:0] im;

  modport source (
    output avail,
    output re,
    output im,
    input  take
  );

  modport sink (
    input  avail,
    input  re,
    input  im,
    output take
  );

endinterface

/* logic/sample_framer.sv */
`timescale 1ns/1ps

module sample_framer #(
  parameter int LENGTH = correlator_pkg::DEFAULT_LENGTH
) (
  input  logic clock_i,
  input  logic reset_i,
  input  logic sample_valid_i,
  input  logic ai_i,
  input  logic aq_i,
  input  logic bi_i,
  input  logic bq_i,
  output logic valid_o,
  output logic first_o,
  output logic last_o,
  output logic ai_o,
  output logic aq_o,
  output logic bi_o,
  output logic bq_o
);

  localparam int COUNT_W = (LENGTH > 1) ? $clog2(LENGTH) : 1;

  logic [COUNT_W-1:0] count_q;
  logic               at_first;
  logic               at_last;

  assign at_first = count_q == '0;
  assign at_last  = count_q == COUNT_W'(LENGTH - 1);

  // Sample position within the frame, only valid samples count
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (sample_valid_i) begin
      count_q <= at_last ? '0 : count_q + 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      first_o <= 1'b0;
      last_o  <= 1'b0;
    end else begin
      valid_o <= sample_valid_i;
      first_o <= sample_valid_i && at_first;
      last_o  <= sample_valid_i && at_last;
    end
  end

  // Sign bits, meaningful only with valid_o
  always_ff @(posedge clock_i) begin
    ai_o <= ai_i;
    aq_o <= aq_i;
    bi_o <= bi_i;
    bq_o <= bq_i;
  end

endmodule

/* logic/correlate.sv */
`timescale 1ns/1ps

module correlate #(
  parameter int WIDTH = correlator_pkg::DEFAULT_WIDTH
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       valid_i,
  input  logic       first_i,
  input  logic       last_i,
  input  logic       ai_i,
  input  logic       aq_i,
  input  logic       bi_i,
  input  logic       bq_i,
  vis_push_if.source push
);

  logic [3:0]       pattern;
  logic [1:0]       re_term;
  logic [1:0]       im_term;
  logic [1:0]       re_term_q;
  logic [1:0]       im_term_q;
  logic             valid_q;
  logic             first_q;
  logic             last_q;
  logic             push_valid_q;
  logic [WIDTH-1:0] re_sum_q;
  logic [WIDTH-1:0] im_sum_q;

  assign pattern = {ai_i, aq_i, bi_i, bq_i};

  // One-bit complex product A * conj(B), offset by one so terms are 0..2
  always_comb begin
    case (pattern)
      4'h0, 4'h5, 4'ha, 4'hf: re_term = 2'd2;
      4'h3, 4'h6, 4'h9, 4'hc: re_term = 2'd0;
      default:                re_term = 2'd1;
    endcase
    case (pattern)
      4'h1, 4'h7, 4'h8, 4'he: im_term = 2'd2;
      4'h2, 4'h4, 4'hb, 4'hd: im_term = 2'd0;
      default:                im_term = 2'd1;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q      <= 1'b0;
      first_q      <= 1'b0;
      last_q       <= 1'b0;
      push_valid_q <= 1'b0;
    end else begin
      valid_q      <= valid_i;
      first_q      <= first_i;
      last_q       <= last_i;
      // Sums are final the cycle after the last term is added
      push_valid_q <= valid_q && last_q;
    end
  end

  // Stage one holds the terms
  always_ff @(posedge clock) begin
    if (valid_i) begin
      re_term_q <= re_term;
      im_term_q <= im_term;
    end
  end

  // Stage two restarts on the first sample of a frame
  always_ff @(posedge clock) begin
    if (valid_q) begin
      if (first_q) begin
        re_sum_q <= WIDTH'(re_term_q);
        im_sum_q <= WIDTH'(im_term_q);
      end else begin
        re_sum_q <= re_sum_q + WIDTH'(re_term_q);
        im_sum_q <= im_sum_q + WIDTH'(im_term_q);
      end
    end
  end

  assign push.valid = push_valid_q;
  assign push.re    = re_sum_q;
  assign push.im    = im_sum_q;

endmodule

/* logic/visibility_fifo.sv */
`timescale 1ns/1ps

module visibility_fifo #(
  parameter int WIDTH = correlator_pkg::DEFAULT_WIDTH,
  parameter int DEPTH = correlator_pkg::DEFAULT_DEPTH
) (
  input  logic      clock,
  input  logic      reset,
  vis_push_if.sink  push,
  vis_pop_if.source pop,
  output logic      overflow_o
);

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]   re_mem [DEPTH];
  logic [WIDTH-1:0]   im_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [COUNT_W-1:0] count_q;
  logic               full;
  logic               write_en;
  logic               read_en;

  // Wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = count_q == COUNT_W'(DEPTH);
  assign write_en = push.valid && !full;
  assign read_en  = pop.take && pop.avail;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (write_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (read_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({write_en, read_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Dropped visibility, held until reset
      if (push.valid && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      re_mem[wr_ptr_q] <= push.re;
      im_mem[wr_ptr_q] <= push.im;
    end
  end

  assign pop.avail = count_q != '0;
  assign pop.re    = re_mem[rd_ptr_q];
  assign pop.im    = im_mem[rd_ptr_q];

endmodule

/* logic/visibility_sender.sv */
`timescale 1ns/1ps

module visibility_sender #(
  parameter int WIDTH = correlator_pkg::DEFAULT_WIDTH
) (
  input  logic             clock,
  input  logic             reset,
  vis_pop_if.sink          pop,
  output logic             vis_req_o,
  input  logic             vis_ack_i,
  output logic [WIDTH-1:0] vis_re_o,
  output logic [WIDTH-1:0] vis_im_o
);

  correlator_pkg::sender_state_t state_q;
  logic                          req_q;
  logic [WIDTH-1:0]              re_q;
  logic [WIDTH-1:0]              im_q;

  // Take the head entry only between handshakes
  assign pop.take = (state_q == correlator_pkg::SEND_IDLE) && pop.avail;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= correlator_pkg::SEND_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        correlator_pkg::SEND_IDLE: begin
          if (pop.avail) begin
            state_q <= correlator_pkg::SEND_REQ;
            req_q   <= 1'b1;
          end
        end
        correlator_pkg::SEND_REQ: begin
          if (vis_ack_i) begin
            state_q <= correlator_pkg::SEND_RELEASE;
            req_q   <= 1'b0;
          end
        end
        correlator_pkg::SEND_RELEASE: begin
          // Wait for the receiver to drop ack
          if (!vis_ack_i) begin
            state_q <= correlator_pkg::SEND_IDLE;
          end
        end
        default: begin
          state_q <= correlator_pkg::SEND_IDLE;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

  // Holding register, stable for the whole handshake
  always_ff @(posedge clock) begin
    if (pop.take) begin
      re_q <= pop.re;
      im_q <= pop.im;
    end
  end

  assign vis_req_o = req_q;
  assign vis_re_o  = re_q;
  assign vis_im_o  = im_q;

endmodule

/* logic/correlator_top.sv */
`timescale 1ns/1ps

module correlator_top #(
  parameter int WIDTH  = correlator_pkg::DEFAULT_WIDTH,
  parameter int LENGTH = correlator_pkg::DEFAULT_LENGTH,
  parameter int DEPTH  = correlator_pkg::DEFAULT_DEPTH
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             sample_valid_i,
  input  logic             ai_i,
  input  logic             aq_i,
  input  logic             bi_i,
  input  logic             bq_i,
  output logic             vis_req_o,
  input  logic             vis_ack_i,
  output logic [WIDTH-1:0] vis_re_o,
  output logic [WIDTH-1:0] vis_im_o,
  output logic             overflow_o
);

  // Framed samples
  logic frame_valid;
  logic frame_first;
  logic frame_last;
  logic frame_ai;
  logic frame_aq;
  logic frame_bi;
  logic frame_bq;

  vis_push_if #(.WIDTH(WIDTH)) push_if ();
  vis_pop_if #(.WIDTH(WIDTH)) pop_if ();

  sample_framer #(
    .LENGTH(LENGTH)
  ) framer_i (
    .clock_i       (clock),
    .reset_i       (reset),
    .sample_valid_i(sample_valid_i),
    .ai_i          (ai_i),
    .aq_i          (aq_i),
    .bi_i          (bi_i),
    .bq_i          (bq_i),
    .valid_o       (frame_valid),
    .first_o       (frame_first),
    .last_o        (frame_last),
    .ai_o          (frame_ai),
    .aq_o          (frame_aq),
    .bi_o          (frame_bi),
    .bq_o          (frame_bq)
  );

  correlate #(
    .WIDTH(WIDTH)
  ) correlate_i (
    .clock  (clock),
    .reset  (reset),
    .valid_i(frame_valid),
    .first_i(frame_first),
    .last_i (frame_last),
    .ai_i   (frame_ai),
    .aq_i   (frame_aq),
    .bi_i   (frame_bi),
    .bq_i   (frame_bq),
    .push   (push_if.source)
  );

  visibility_fifo #(
    .WIDTH(WIDTH),
    .DEPTH(DEPTH)
  ) fifo_i (
    .clock     (clock),
    .reset     (reset),
    .push      (push_if.sink),
    .pop       (pop_if.source),
    .overflow_o(overflow_o)
  );

  visibility_sender #(
    .WIDTH(WIDTH)
  ) sender_i (
    .clock    (clock),
    .reset    (reset),
    .pop      (pop_if.sink),
    .vis_req_o(vis_req_o),
    .vis_ack_i(vis_ack_i),
    .vis_re_o (vis_re_o),
    .vis_im_o (vis_im_o)
  );

endmodule

/* verification/correlator_tb.sv */
`timescale 1ns/1ps

module correlator_tb;

  localparam int WIDTH    = correlator_pkg::DEFAULT_WIDTH;
  localparam int LEN      = correlator_pkg::DEFAULT_LENGTH;
  localparam int DEPTH    = correlator_pkg::DEFAULT_DEPTH;
  localparam int NUM_ROWS = 7;
  localparam int TIMEOUT  = 2000;

  logic             clock = 1'b0;
  logic             reset;
  logic             sample_valid_i;
  logic             ai_i;
  logic             aq_i;
  logic             bi_i;
  logic             bq_i;
  logic             vis_req_o;
  logic             vis_ack_i = 1'b0;
  logic [WIDTH-1:0] vis_re_o;
  logic [WIDTH-1:0] vis_im_o;
  logic             overflow_o;

  // Stimulus table with one array per column
  string      row_name      [NUM_ROWS];
  bit         row_random    [NUM_ROWS];
  logic [3:0] row_pattern   [NUM_ROWS];
  int         row_gap_pct   [NUM_ROWS];
  int         row_ack_delay [NUM_ROWS];
  int         row_frames    [NUM_ROWS];
  bit         row_hold      [NUM_ROWS];
  int         row_exp_re    [NUM_ROWS];
  int         row_exp_im    [NUM_ROWS];
  int         rows_added = 0;

  // Scoreboard and responder state
  int               exp_re_q [$];
  int               exp_im_q [$];
  string            current_name = "reset";
  int               ack_delay = 0;
  bit               hold_ack = 1'b0;
  bit               req_seen = 1'b0;
  int               wait_count = 0;
  logic [WIDTH-1:0] seen_re;
  logic [WIDTH-1:0] seen_im;
  int               seed = 3;

  correlator_top dut_i (
    .clock         (clock),
    .reset         (reset),
    .sample_valid_i(sample_valid_i),
    .ai_i          (ai_i),
    .aq_i          (aq_i),
    .bi_i          (bi_i),
    .bq_i          (bq_i),
    .vis_req_o     (vis_req_o),
    .vis_ack_i     (vis_ack_i),
    .vis_re_o      (vis_re_o),
    .vis_im_o      (vis_im_o),
    .overflow_o    (overflow_o)
  );

  always #20 clock = ~clock;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abort_run($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic add_row(input string name, input bit random, input logic [3:0] pattern,
                         input int gap_pct, input int delay, input int frames,
                         input bit hold, input int exp_re, input int exp_im);
    row_name[rows_added]      = name;
    row_random[rows_added]    = random;
    row_pattern[rows_added]   = pattern;
    row_gap_pct[rows_added]   = gap_pct;
    row_ack_delay[rows_added] = delay;
    row_frames[rows_added]    = frames;
    row_hold[rows_added]      = hold;
    row_exp_re[rows_added]    = exp_re;
    row_exp_im[rows_added]    = exp_im;
    rows_added++;
  endtask

  // Re of A * conj(B) plus one counts the matching I and Q signs
  function automatic int model_re(input logic [3:0] p);
    return int'(p[3] == p[1]) + int'(p[2] == p[0]);
  endfunction

  // Im term is aq*bi - ai*bq offset to 0..2
  function automatic int model_im(input logic [3:0] p);
    return int'(p[2] == p[1]) + int'(p[3] != p[0]);
  endfunction

  task automatic drive_sample(input bit valid, input logic [3:0] p);
    @(negedge clock);
    sample_valid_i = valid;
    {ai_i, aq_i, bi_i, bq_i} = p;
  endtask

  task automatic send_frame(input int row, input bit expect_out);
    int         re_sum;
    int         im_sum;
    logic [3:0] p;
    re_sum = 0;
    im_sum = 0;
    for (int n = 0; n < LEN; n++) begin
      // Gap cycles carry random bits that must be ignored
      while (int'($unsigned($random(seed)) % 100) < row_gap_pct[row]) begin
        drive_sample(1'b0, 4'($random(seed)));
      end
      p = row_random[row] ? 4'($random(seed)) : row_pattern[row];
      drive_sample(1'b1, p);
      re_sum += model_re(p);
      im_sum += model_im(p);
    end
    if (expect_out) begin
      exp_re_q.push_back(row_random[row] ? re_sum : row_exp_re[row]);
      exp_im_q.push_back(row_random[row] ? im_sum : row_exp_im[row]);
    end
  endtask

  task automatic wait_overflow();
    int n;
    n = 0;
    while (!overflow_o) begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) begin
        abort_run($sformatf("%s: overflow flag never went high", current_name));
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_re_q.size() != 0 || vis_req_o || vis_ack_i) begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) begin
        abort_run($sformatf("%s: visibilities were not delivered in time", current_name));
      end
    end
  endtask

  task automatic run_row(input int row);
    int keep;
    current_name = row_name[row];
    ack_delay    = row_ack_delay[row];
    hold_ack     = row_hold[row];
    // With ack held, only the FIFO plus the sender register survive
    keep = row_hold[row] ? DEPTH + 1 : row_frames[row];
    for (int f = 0; f < row_frames[row]; f++) begin
      send_frame(row, f < keep);
    end
    drive_sample(1'b0, 4'h0);
    if (row_hold[row]) begin
      wait_overflow();
      hold_ack = 1'b0;
    end
    wait_drained();
    check_value({current_name, " overflow"}, int'(row_hold[row]), int'(overflow_o));
  endtask

  // Four-phase responder that also checks data is held while req is high
  always @(negedge clock) begin
    if (reset) begin
      req_seen  = 1'b0;
      vis_ack_i = 1'b0;
    end else if (vis_req_o) begin
      if (!req_seen) begin
        req_seen   = 1'b1;
        seen_re    = vis_re_o;
        seen_im    = vis_im_o;
        wait_count = 0;
      end else begin
        check_value({current_name, " held re"}, int'(seen_re), int'(vis_re_o));
        check_value({current_name, " held im"}, int'(seen_im), int'(vis_im_o));
      end
      if (!vis_ack_i && !hold_ack) begin
        if (wait_count >= ack_delay) begin
          if (exp_re_q.size() == 0) begin
            abort_run($sformatf("%s: visibility arrived with none expected", current_name));
          end
          check_value({current_name, " re"}, exp_re_q.pop_front(), int'(vis_re_o));
          check_value({current_name, " im"}, exp_im_q.pop_front(), int'(vis_im_o));
          vis_ack_i = 1'b1;
        end else begin
          wait_count++;
        end
      end
    end else begin
      req_seen = 1'b0;
      if (vis_ack_i) begin
        vis_ack_i = 1'b0;
      end
    end
  end

  initial begin
    reset          = 1'b1;
    sample_valid_i = 1'b0;
    ai_i           = 1'b0;
    aq_i           = 1'b0;
    bi_i           = 1'b0;
    bq_i           = 1'b0;

    // name, random, pattern, gap %, ack delay, frames, hold ack, re, im
    add_row("const_p0",  1'b0, 4'h0, 0,  0,   1,         1'b0, 2 * LEN, LEN);
    add_row("const_p3",  1'b0, 4'h3, 0,  0,   1,         1'b0, 0,       LEN);
    add_row("const_p1",  1'b0, 4'h1, 0,  0,   1,         1'b0, LEN,     2 * LEN);
    add_row("const_p2",  1'b0, 4'h2, 0,  0,   1,         1'b0, LEN,     0);
    add_row("rand_gaps", 1'b1, 4'h0, 30, 1,   3,         1'b0, 0,       0);
    add_row("slow_ack",  1'b1, 4'h0, 10, 120, DEPTH + 1, 1'b0, 0,       0);
    add_row("ack_hold",  1'b1, 4'h0, 0,  2,   DEPTH + 2, 1'b1, 0,       0);

    repeat (10) @(negedge clock);
    reset = 1'b0;
    check_value("reset req", 0, int'(vis_req_o));
    check_value("reset overflow", 0, int'(overflow_o));

    for (int row = 0; row < rows_added; row++) begin
      run_row(row);
    end

    // Dropped frame must never show up
    current_name = "tail";
    for (int n = 0; n < 20; n++) begin
      @(negedge clock);
      check_value("tail req", 0, int'(vis_req_o));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

/* sim.f */
logic/correlator_pkg.sv
logic/vis_push_if.sv
logic/vis_pop_if.sv
logic/sample_framer.sv
logic/correlate.sv
logic/visibility_fifo.sv
logic/visibility_sender.sv
logic/correlator_top.sv
verification/correlator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the correlator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module correlator_tb \
  --Mdir "$BUILD_DIR" -o correlator_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"$BUILD_DIR/correlator_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation passed"
exit 0
